// ==== verilog/core_pkg.sv ====
// Core type definitions
package core_pkg;

    typedef logic [15:0] word_t;                // Data word or program address
    typedef logic [15:0] inst_t;                // Raw instruction word
    typedef logic [2:0]  addr_t;                // Register index

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_LI   = 4'h5,                         // rd = sext(imm9)
        OP_ADDI = 4'h6,                         // rd = rs1 + sext(imm6)
        OP_BNZ  = 4'h7,                         // Branch if rd nonzero
        OP_JMP  = 4'h8                          // pc = rs1
    } op_t;                                     // Codes 9 to 15 are invalid

    typedef enum logic [1:0] {
        ST_BOOT,
        ST_RUN,
        ST_WAIT,
        ST_REDIRECT
    } fetch_state_t;

    // Instruction field extraction
    function automatic op_t inst_op(inst_t i);
        return op_t'(i[15:12]);
    endfunction

    function automatic addr_t inst_rd(inst_t i);
        return i[11:9];
    endfunction

    function automatic addr_t inst_rs1(inst_t i);
        return i[8:6];
    endfunction

    function automatic addr_t inst_rs2(inst_t i);
        return i[5:3];
    endfunction

    function automatic word_t inst_imm6(inst_t i);
        return {{10{i[5]}}, i[5:0]};            // Sign extended
    endfunction

    function automatic word_t inst_imm9(inst_t i);
        return {{7{i[8]}}, i[8:0]};             // Sign extended
    endfunction

endpackage

// ==== verilog/fetch_if.sv ====
// Fetch to execute link
interface fetch_if;
    import core_pkg::*;

    logic  valid;                               // Instruction presented, always consumed
    word_t pc;                                  // Address of presented instruction
    inst_t inst;
    logic  redirect;                            // One-cycle pulse from execute
    word_t target;                              // New PC with redirect

    modport source (
        output valid, pc, inst,
        input  redirect, target
    );

    modport sink (
        input  valid, pc, inst,
        output redirect, target
    );

endinterface

// ==== verilog/retire_if.sv ====
// Execute to retire link
interface retire_if;
    import core_pkg::*;

    logic  valid;                               // Retiring instruction
    logic  load;                                // Writes a register
    addr_t rd_addr;
    word_t rd_data;

    modport source (
        output valid, load, rd_addr, rd_data
    );

    modport sink (
        input  valid, load, rd_addr, rd_data
    );

    // Forwarding tap into execute
    modport monitor (
        input  valid, load, rd_addr, rd_data
    );

endinterface

// ==== verilog/fetch.sv ====
// Instruction fetch stage
module fetch #(
    parameter core_pkg::word_t RESET_BASE = 16'h0000,
    parameter core_pkg::word_t TRAP_BASE  = 16'h0040
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            irq,
    output core_pkg::word_t code_addr,
    input  logic            code_ready,
    input  core_pkg::inst_t code_data,
    fetch_if.source         sink
);
    import core_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    word_t        pc_q;                         // Address being fetched
    word_t        pc_d;
    logic         take;                         // Fetch completes at this edge
    logic         valid_q;
    word_t        ir_pc;                        // PC of held instruction
    inst_t        ir;                           // Held instruction

    assign code_addr = pc_q;                    // Memory answers in same cycle

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        take    = 1'b0;
        case (state_q)
            ST_BOOT: begin
                pc_d    = RESET_BASE;           // First fetch address
                state_d = ST_RUN;
            end
            ST_RUN, ST_WAIT, ST_REDIRECT: begin
                if (code_ready) begin
                    take    = 1'b1;
                    pc_d    = pc_q + 16'd1;     // Sequential advance
                    state_d = ST_RUN;
                end else begin
                    state_d = ST_WAIT;          // Hold address for wait state
                end
            end
            default: state_d = ST_BOOT;
        endcase
        // irq takes priority over an execute redirect
        if (irq) begin
            take    = 1'b0;                     // Squash completing fetch
            pc_d    = TRAP_BASE;
            state_d = ST_REDIRECT;
        end else if (sink.redirect) begin
            take    = 1'b0;                     // The one discarded fetch
            pc_d    = sink.target;
            state_d = ST_REDIRECT;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_BOOT;
            pc_q    <= RESET_BASE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            valid_q <= take;                    // Valid in cycle after completion
        end
    end

    // Instruction register toward execute
    always_ff @(posedge clk) begin
        if (take) begin
            ir    <= code_data;
            ir_pc <= pc_q;
        end
    end

    assign sink.valid = valid_q;
    assign sink.pc    = ir_pc;
    assign sink.inst  = ir;

endmodule

// ==== verilog/regfile.sv ====
// General purpose register file
module regfile (
    input  logic            clk,
    input  core_pkg::addr_t rs1_addr,
    input  core_pkg::addr_t rs2_addr,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data,
    input  logic            rd_en,
    input  core_pkg::addr_t rd_addr,
    input  core_pkg::word_t rd_data
);
    import core_pkg::*;

    word_t regs [8];                            // Eight general registers

    // Single write port
    always_ff @(posedge clk) begin
        if (rd_en) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Asynchronous reads, bypass lives in execute
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== verilog/execute.sv ====
// Decode and execute stage
module execute #(
    parameter core_pkg::word_t TRAP_BASE = 16'h0040
) (
    input  logic            clk,
    input  logic            arst_n,
    fetch_if.sink           source,
    output core_pkg::addr_t rs1_addr,
    output core_pkg::addr_t rs2_addr,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    retire_if.source        result,
    retire_if.monitor       bypass
);
    import core_pkg::*;

    op_t   op;
    addr_t rd;
    word_t opa;                                 // Forwarded rs1 value
    word_t opb;                                 // Forwarded rs2 or rd value
    word_t alu;
    logic  load;                                // Instruction writes rd
    logic  invalid;                             // Undefined opcode
    logic  taken;                               // Control transfer
    word_t target;
    logic  fwd_a;
    logic  fwd_b;

    // Decode
    assign op       = inst_op(source.inst);
    assign rd       = inst_rd(source.inst);
    assign rs1_addr = inst_rs1(source.inst);
    assign rs2_addr = (op == OP_BNZ) ? rd : inst_rs2(source.inst); // BNZ tests rd

    // Retiring result overrides stale regfile data
    assign fwd_a = bypass.valid && bypass.load && (bypass.rd_addr == rs1_addr);
    assign fwd_b = bypass.valid && bypass.load && (bypass.rd_addr == rs2_addr);
    assign opa   = fwd_a ? bypass.rd_data : rs1_data;
    assign opb   = fwd_b ? bypass.rd_data : rs2_data;

    always_comb begin
        alu     = '0;
        load    = 1'b1;
        invalid = 1'b0;
        taken   = 1'b0;
        target  = TRAP_BASE;
        case (op)
            OP_ADD:  alu = opa + opb;
            OP_SUB:  alu = opa - opb;           // Wraps modulo 2^16
            OP_AND:  alu = opa & opb;
            OP_OR:   alu = opa | opb;
            OP_XOR:  alu = opa ^ opb;
            OP_LI:   alu = inst_imm9(source.inst);
            OP_ADDI: alu = opa + inst_imm6(source.inst);
            OP_BNZ: begin
                load   = 1'b0;
                taken  = (opb != '0);
                target = source.pc + 16'd1 + inst_imm9(source.inst); // PC relative
            end
            OP_JMP: begin
                load   = 1'b0;
                taken  = 1'b1;
                target = opa;                   // Register indirect
            end
            default: begin
                load    = 1'b0;
                invalid = 1'b1;                 // Trap, target stays TRAP_BASE
            end
        endcase
    end

    assign source.redirect = source.valid & (taken | invalid);
    assign source.target   = target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result.valid <= 1'b0;
            result.load  <= 1'b0;
        end else begin
            result.valid <= source.valid & ~invalid; // Invalid does not retire
            result.load  <= source.valid & load;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        result.rd_addr <= rd;
        result.rd_data <= alu;
    end

endmodule

// ==== verilog/retire.sv ====
// Retire stage and write counter
module retire (
    input  logic            clk,
    input  logic            arst_n,
    retire_if.sink          source,
    output logic            rd_en,
    output core_pkg::addr_t rd_addr,
    output core_pkg::word_t rd_data,
    output core_pkg::word_t count
);

    // Register write strobe
    assign rd_en   = source.valid & source.load;
    assign rd_addr = source.rd_addr;
    assign rd_data = source.rd_data;

    // Tally of retired register writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (rd_en) begin
            count <= count + 16'd1;             // Wraps at 2^16
        end
    end

endmodule

// ==== verilog/cpu.sv ====
// Three stage pipelined core
module cpu #(
    parameter core_pkg::word_t RESET_BASE = 16'h0000,
    parameter core_pkg::word_t TRAP_BASE  = 16'h0040
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            irq,
    output core_pkg::word_t code_addr,
    input  logic            code_ready,
    input  core_pkg::inst_t code_data,
    output logic            rd_en,
    output core_pkg::addr_t rd_addr,
    output core_pkg::word_t rd_data,
    output core_pkg::word_t count
);
    import core_pkg::*;

    fetch_if  fch ();                           // Fetch to execute
    retire_if ret ();                           // Execute to retire

    addr_t rs1_addr;
    addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;

    fetch #(
        .RESET_BASE (RESET_BASE),
        .TRAP_BASE  (TRAP_BASE)
    ) fetch (
        .clk,
        .arst_n,
        .irq,
        .code_addr,
        .code_ready,
        .code_data,
        .sink       (fch.source)
    );

    regfile regfile (
        .clk,
        .rs1_addr,
        .rs2_addr,
        .rs1_data,
        .rs2_data,
        .rd_en,                                 // Written from retire
        .rd_addr,
        .rd_data
    );

    execute #(
        .TRAP_BASE  (TRAP_BASE)
    ) execute (
        .clk,
        .arst_n,
        .source     (fch.sink),
        .rs1_addr,
        .rs2_addr,
        .rs1_data,
        .rs2_data,
        .result     (ret.source),
        .bypass     (ret.monitor)               // Forwarding path
    );

    retire retire (
        .clk,
        .arst_n,
        .source     (ret.sink),
        .rd_en,
        .rd_addr,
        .rd_data,
        .count
    );

endmodule

// ==== test/cpu_props.sv ====
// Core protocol assertions
module cpu_props (
    input logic            clk,
    input logic            arst_n,
    input logic            irq,
    input core_pkg::word_t code_addr,
    input logic            code_ready,
    input logic            rd_en,
    input core_pkg::word_t count,
    input logic            redirect
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;                         // Read by the testbench

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !rd_en)
        else begin
            $error("rd_en high while reset is held");
            fail_count++;
        end

    // Counter steps once per retired write
    a_count_step: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |=> count == $past(count) + 16'd1)
        else begin
            $error("count did not advance after rd_en");
            fail_count++;
        end

    a_count_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !rd_en |=> $stable(count))
        else begin
            $error("count changed without rd_en");
            fail_count++;
        end

    // Wait state holds the fetch address
    a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (!code_ready && !irq && !redirect) |=> $stable(code_addr))
        else begin
            $error("code_addr moved during a wait state");
            fail_count++;
        end

endmodule

bind cpu cpu_props props (
    .clk        (clk),
    .arst_n     (arst_n),
    .irq        (irq),
    .code_addr  (code_addr),
    .code_ready (code_ready),
    .rd_en      (rd_en),
    .count      (count),
    .redirect   (fch.redirect)                  // Execute redirect pulse
);

// ==== test/cpu_tb.sv ====
// CPU testbench
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int unsigned SEED       = 32'hb0e2_7a2f;
    localparam string       VEC_FILE   = "test/cpu_vectors.txt";

    logic  clk;
    logic  arst_n;
    logic  irq;
    logic  code_ready;
    word_t code_addr;
    inst_t code_data;
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;
    word_t count;

    inst_t mem [65536];                         // Instruction memory model
    addr_t exp_addr [$];                        // Expected write sequence
    word_t exp_data [$];
    int    irq_after [$];                       // Write counts that trigger irq
    int    seen   = 0;                          // Writes observed so far
    bit    loaded = 1'b0;

    cpu #(
        .RESET_BASE (16'h0000),
        .TRAP_BASE  (16'h0040)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .irq        (irq),
        .code_addr  (code_addr),
        .code_ready (code_ready),
        .code_data  (code_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .count      (count)
    );

    assign code_data = mem[code_addr];          // Combinational memory

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(string name, word_t got, word_t want);
        if (got !== want) begin
            stop_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    // Invalid opcode F, low bits mixed from the whole address
    function automatic inst_t fill_word(int unsigned a);
        word_t w;
        w = word_t'(a);
        return 16'hF000 | ((w ^ (w >> 8) ^ (w >> 12)) & 16'h0FFF);
    endfunction

    task automatic load_vectors();
        int    fd;
        int    n;
        int    cnt;
        string line;
        byte   kind;
        word_t a;
        word_t b;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            stop_run("Cannot open the vector file test/cpu_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 2) begin
                    kind = line[0];                         // Lines with # are skipped
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    case (kind)
                        "M": if (n == 2) mem[a] = b;
                        "I": begin
                            if ($sscanf(line.substr(1, line.len() - 1), "%d", cnt) == 1) begin
                                irq_after.push_back(cnt);   // Write count in decimal
                            end
                        end
                        "W": begin
                            if (n == 2) begin
                                exp_addr.push_back(addr_t'(a));
                                exp_data.push_back(b);
                            end
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Wait states, one cycle in four
    task automatic drive_code_ready();
        forever begin
            @(posedge clk);
            code_ready <= ($urandom % 4) != 0;
        end
    endtask

    // irq pulse after a random extra delay
    task automatic raise_irqs();
        foreach (irq_after[i]) begin
            wait (seen >= irq_after[i]);
            @(posedge clk);
            repeat ($urandom % 8) @(posedge clk);
            irq <= 1'b1;
            @(posedge clk);
            irq <= 1'b0;
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        irq        = 1'b0;
        code_ready = 1'b0;
        void'($urandom(SEED));                  // One seed for the whole run
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(a);
        end
        load_vectors();
        loaded = 1'b1;
        fork
            drive_code_ready();                 // Random streams derive from the seed
            raise_irqs();
        join_none
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        wait (seen == exp_data.size());
        repeat (4) @(posedge clk);              // Room for a stray write
        if (DUT.props.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("A bound assertion in cpu_props failed");
        end
    end

    // Checker, samples mid cycle
    always @(negedge clk) begin
        if (arst_n === 1'b1 && rd_en === 1'b1) begin
            if (seen >= exp_data.size()) begin
                stop_run($sformatf("Unexpected write to r%0d at %0t", rd_addr, $time));
            end else begin
                check_value("rd_addr", word_t'(rd_addr), word_t'(exp_addr[seen]));
                check_value("rd_data", rd_data, exp_data[seen]);
                check_value("count", count, word_t'(seen)); // Old value before this write
                seen = seen + 1;
            end
        end
        if (DUT.props.fail_count != 0) begin
            stop_run("A bound assertion in cpu_props failed");
        end
    end

    // Watchdog, 20 cycles per expected write plus margin
    initial begin
        wait (loaded);
        repeat (20 * exp_data.size() + 200) @(posedge clk);
        stop_run($sformatf("Watchdog expired with %0d of %0d writes seen",
                           seen, exp_data.size()));
    end

endmodule

// ==== src.f ====
verilog/core_pkg.sv
verilog/fetch_if.sv
verilog/retire_if.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/execute.sv
verilog/retire.sv
verilog/cpu.sv
test/cpu_props.sv
test/cpu_tb.sv

// ==== test/cpu_vectors.txt ====
# M addr inst is a program word, I n raises irq after n writes
# W reg value is the next expected register write, all fields hex
M 00 5205
M 01 55FD
M 02 0688
M 03 1888
M 04 2AE0
M 05 7A01
M 06 3CE0
M 07 4D90
M 08 6DB0
M 09 7C01
M 0A 5AAA
M 0B 5E10
M 0C 81C0
M 10 5E14
M 11 F000
M 14 5E18
M 15 7FFF
M 18 5A18
M 19 7FFF
# Trap handler bumps r6 and jumps through r7
M 40 6D81
M 41 81C0
W 1 0005
W 2 FFFD
W 3 0002
W 4 FFF8
W 5 0000
W 6 FFFA
W 6 0007
W 6 FFF7
W 7 0010
W 7 0014
# Invalid opcode at 11 leads to the handler
W 6 FFF8
W 7 0018
I 12
W 6 FFF9
W 5 0018
